// File: crcu_regs.f
+incdir+verilog
verilog/crcu_pkg.sv
verilog/crcu_reg_if.sv
verilog/apb_access_ctrl.sv
verilog/crcu_reg_bank.sv
verilog/crcu_regs.sv
dv/crcu_regs_asserts.sv
dv/crcu_regs_tb.sv

// File: dv/crcu_regs_asserts.sv
/*
  APB response rules for the register block, checked on every clock.
  Bound into the top level so it watches the slave ports directly.
  Covers the single cycle PREADY pulse, its fixed delay after PENABLE
  and PSLVERR qualification.
*/
`timescale 1ns/1ps

module crcu_regs_asserts (
	input logic PCLK,
	input logic PRESETN,
	input logic PSEL,
	input logic PENABLE,
	input logic PREADY,
	input logic PSLVERR
);

	// Response lasts one cycle
	a_ready_pulse: assert property (@(posedge PCLK) disable iff (!PRESETN)
		PREADY |=> !PREADY)
		else $error("PREADY high for two cycles in a row");

	// No response in the first access cycle
	a_ready_not_early: assert property (@(posedge PCLK) disable iff (!PRESETN)
		$rose(PSEL && PENABLE) |-> !PREADY)
		else $error("PREADY high in the first access cycle");

	// Response exactly one cycle after access starts
	a_ready_on_time: assert property (@(posedge PCLK) disable iff (!PRESETN)
		$rose(PSEL && PENABLE) |=> PREADY)
		else $error("PREADY missing one cycle after PENABLE");

	// Error flag only with the response
	a_err_qualified: assert property (@(posedge PCLK) disable iff (!PRESETN)
		PSLVERR |-> PREADY)
		else $error("PSLVERR high without PREADY");

endmodule

bind crcu_regs crcu_regs_asserts asserts_i (
	.PCLK    (PCLK),
	.PRESETN (PRESETN),
	.PSEL    (PSEL),
	.PENABLE (PENABLE),
	.PREADY  (PREADY),
	.PSLVERR (PSLVERR)
);

// File: dv/crcu_regs_tb.sv
/*
  Testbench for the clock and reset control unit register block.
  Builds a table of APB transfers with expected read data and PSLVERR,
  plays it through a simple APB master and checks each response, its
  timing, and both control output buses against a small register model.
  Ends with one summary line and the overall verdict.
*/
`timescale 1ns/1ps

`include "crcu_defs.svh"

module crcu_regs_tb
	import crcu_pkg::*;
();

	// One table row
	typedef struct packed {
		logic       wr;        // 1 write, 0 read
		crcu_addr_t addr;
		crcu_word_t wdata;
		crcu_word_t exp_rdata; // Zero for writes and errors
		logic       exp_err;   // Expected PSLVERR
	} xfer_t;

	logic       PCLK;
	logic       PRESETN;
	logic       PSEL;
	logic       PENABLE;
	logic       PWRITE;
	crcu_addr_t PADDR;
	crcu_word_t PWDATA;
	logic       PREADY;
	logic       PSLVERR;
	crcu_word_t PRDATA;
	crcu_bank_t clk_ctl;
	crcu_bank_t rst_ctl;

	xfer_t      xfer_q[$];   // Stimulus table
	crcu_bank_t clk_model;   // Expected clk_ctl
	crcu_bank_t rst_model;   // Expected rst_ctl
	int         value_errs;  // Wrong data, error flag or bus
	int         timing_errs; // Wrong handshake timing
	int         cycle_cnt;   // Clock edges since start
	int         cycle_limit; // Run guard from table length
	logic       ready_q;     // PREADY one cycle back

	crcu_regs dut_i (
		.PCLK    (PCLK),
		.PRESETN (PRESETN),
		.PSEL    (PSEL),
		.PENABLE (PENABLE),
		.PWRITE  (PWRITE),
		.PADDR   (PADDR),
		.PWDATA  (PWDATA),
		.PREADY  (PREADY),
		.PSLVERR (PSLVERR),
		.PRDATA  (PRDATA),
		.clk_ctl (clk_ctl),
		.rst_ctl (rst_ctl)
	);

	always #2 PCLK = ~PCLK; // 4 ns period

	// Stops a stuck transfer
	always @(posedge PCLK) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout reached after %0d cycles, a transfer never completed", cycle_cnt);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// Response rules on every cycle out of reset
	always @(negedge PCLK) begin
		if (PRESETN === 1'b1) begin
			if (PREADY === 1'b1 && ready_q === 1'b1) begin
				$display("Error at %0t: PREADY high for two cycles in a row", $time);
				timing_errs++;
			end
			if (PSLVERR === 1'b1 && PREADY !== 1'b1) begin
				$display("Error at %0t: PSLVERR high without PREADY", $time);
				timing_errs++;
			end
		end
		ready_q = PREADY;
	end

	// Distinct words per offset
	function automatic crcu_word_t clk_val(input int i);
		return 32'hC1C0_0000 + i * 32'h0000_1111;
	endfunction

	function automatic crcu_word_t rst_val(input int i);
		return 32'hA5E0_0000 + i * 32'h0000_2222;
	endfunction

	function automatic void add_entry(input logic wr, input crcu_addr_t addr,
		input crcu_word_t wdata, input crcu_word_t exp_rdata, input logic exp_err);
		xfer_t x;
		x.wr        = wr;
		x.addr      = addr;
		x.wdata     = wdata;
		x.exp_rdata = exp_rdata;
		x.exp_err   = exp_err;
		xfer_q.push_back(x);
	endfunction

	function automatic void build_table();
		crcu_addr_t bad_addr[3];
		bad_addr[0] = 32'h0000_0080; // Just past the map
		bad_addr[1] = 32'h0000_1002; // Misaligned
		bad_addr[2] = 32'hFFFF_FFFC; // Top of address space
		for (int i = 0; i < 32; i++) begin // Whole map reads zero after reset
			add_entry(1'b0, crcu_addr_t'(i * 4), '0, '0, 1'b0);
		end
		for (int i = 0; i < `CRCU_BANK_WORDS; i++) begin
			add_entry(1'b1, `CRCU_CLK_CTL_BASE + i * 4, clk_val(i), '0, 1'b0);
		end
		for (int i = 0; i < `CRCU_BANK_WORDS; i++) begin
			add_entry(1'b0, `CRCU_CLK_CTL_BASE + i * 4, '0, clk_val(i), 1'b0);
			add_entry(1'b0, `CRCU_CLK_STS_BASE + i * 4, '0, clk_val(i), 1'b0); // Mirror
		end
		for (int i = 0; i < `CRCU_BANK_WORDS; i++) begin
			add_entry(1'b1, `CRCU_RST_CTL_BASE + i * 4, rst_val(i), '0, 1'b0);
		end
		for (int i = 0; i < `CRCU_BANK_WORDS; i++) begin
			add_entry(1'b0, `CRCU_RST_CTL_BASE + i * 4, '0, rst_val(i), 1'b0);
			add_entry(1'b0, `CRCU_RST_STS_BASE + i * 4, '0, rst_val(i), 1'b0);
		end
		// Status words refuse writes and the control word behind them holds
		add_entry(1'b1, `CRCU_CLK_STS_BASE, 32'hDEAD_BEEF, '0, 1'b1);
		add_entry(1'b0, `CRCU_CLK_CTL_BASE, '0, clk_val(0), 1'b0);
		add_entry(1'b1, `CRCU_CLK_STS_BASE + 32'h1C, 32'hDEAD_BEEF, '0, 1'b1);
		add_entry(1'b0, `CRCU_CLK_CTL_BASE + 32'h1C, '0, clk_val(7), 1'b0);
		add_entry(1'b1, `CRCU_RST_STS_BASE, 32'hBAAD_F00D, '0, 1'b1);
		add_entry(1'b0, `CRCU_RST_CTL_BASE, '0, rst_val(0), 1'b0);
		add_entry(1'b1, `CRCU_RST_STS_BASE + 32'h1C, 32'hBAAD_F00D, '0, 1'b1);
		add_entry(1'b0, `CRCU_RST_CTL_BASE + 32'h1C, '0, rst_val(7), 1'b0);
		for (int b = 0; b < 3; b++) begin
			add_entry(1'b0, bad_addr[b], '0, '0, 1'b1);
			add_entry(1'b1, bad_addr[b], 32'h5A5A_5A5A, '0, 1'b1);
		end
	endfunction

	// Only clean writes to a control region change state
	function automatic void update_model(input xfer_t x);
		crcu_idx_t w;
		w = crcu_idx_t'(x.addr[4:2]);
		if (x.wr && !x.exp_err) begin
			if (x.addr < `CRCU_CLK_STS_BASE) begin
				clk_model[w] = x.wdata;
			end else if (x.addr >= `CRCU_RST_CTL_BASE && x.addr < `CRCU_RST_STS_BASE) begin
				rst_model[w] = x.wdata;
			end
		end
	endfunction

	task automatic init_inputs();
		PRESETN <= 1'b0;
		PSEL    <= 1'b0;
		PENABLE <= 1'b0;
		PWRITE  <= 1'b0;
		PADDR   <= '0;
		PWDATA  <= '0;
	endtask

	task automatic apply_reset();
		repeat (5) @(posedge PCLK);
		PRESETN <= 1'b1;
	endtask

	// One APB transfer checked in its PREADY cycle
	task automatic apb_transfer(input xfer_t x);
		int waits;
		waits = 0;
		@(posedge PCLK);
		PSEL    <= 1'b1; // Setup phase
		PENABLE <= 1'b0;
		PWRITE  <= x.wr;
		PADDR   <= x.addr;
		PWDATA  <= x.wr ? x.wdata : '0;
		@(posedge PCLK);
		PENABLE <= 1'b1; // Access phase
		@(negedge PCLK);
		waits = 1;
		while (!PREADY) begin
			if (PRDATA !== '0 || PSLVERR !== 1'b0) begin
				$display("Error at %0t: PRDATA or PSLVERR active before PREADY", $time);
				timing_errs++;
			end
			@(negedge PCLK);
			waits++;
		end
		update_model(x);
		if (waits != 2) begin // PREADY one cycle after PENABLE
			$display("Error at %0t: PREADY came %0d cycles after PENABLE at 0x%08h",
				$time, waits - 1, x.addr);
			timing_errs++;
		end
		if (PSLVERR !== x.exp_err) begin
			$display("Error at %0t: %s 0x%08h gave PSLVERR %b, expected %b",
				$time, x.wr ? "write" : "read", x.addr, PSLVERR, x.exp_err);
			value_errs++;
		end
		if (PRDATA !== x.exp_rdata) begin
			$display("Error at %0t: %s 0x%08h gave PRDATA 0x%08h, expected 0x%08h",
				$time, x.wr ? "write" : "read", x.addr, PRDATA, x.exp_rdata);
			value_errs++;
		end
		if (clk_ctl !== clk_model) begin // Also catches late write
			$display("Error at %0t: clk_ctl is %h, expected %h", $time, clk_ctl, clk_model);
			value_errs++;
		end
		if (rst_ctl !== rst_model) begin
			$display("Error at %0t: rst_ctl is %h, expected %h", $time, rst_ctl, rst_model);
			value_errs++;
		end
		@(posedge PCLK);
		PSEL    <= 1'b0; // Back to idle
		PENABLE <= 1'b0;
	endtask

	initial begin
		PCLK        = 1'b0;
		cycle_cnt   = 0;
		value_errs  = 0;
		timing_errs = 0;
		ready_q     = 1'b0;
		clk_model   = {`CRCU_BANK_WORDS{crcu_word_t'(`CRCU_CTL_RESET)}};
		rst_model   = {`CRCU_BANK_WORDS{crcu_word_t'(`CRCU_CTL_RESET)}};
		build_table();
		cycle_limit = xfer_q.size() * 4 + 20; // Four cycles per transfer
		init_inputs();
		apply_reset();
		foreach (xfer_q[n]) begin
			apb_transfer(xfer_q[n]);
		end
		@(negedge PCLK);
		$display("Summary: %0d transfers, %0d value errors, %0d timing errors",
			xfer_q.size(), value_errs, timing_errs);
		if (value_errs + timing_errs == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator and run; pass only if the testbench prints its pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module crcu_regs_tb \
	-f crcu_regs.f \
	-o crcu_regs_sim || { echo "Verilator build failed"; exit 1; }

sim_out=$(./obj_dir/crcu_regs_sim +verilator+error+limit+1000)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "NO ERRORS" && echo "Simulation passed" || {
	echo "Simulation failed"
	exit 1
}

// File: verilog/apb_access_ctrl.sv
/*
  APB slave protocol engine for the register block.
  Follows setup and access phases, fires one read or write strobe in the
  first access cycle, and registers the bank's answer so the transfer
  always completes with exactly one wait state.
*/
`timescale 1ns/1ps

module apb_access_ctrl
	import crcu_pkg::*;
(
	input  logic       PCLK,
	input  logic       PRESETN,  // Synchronous, active low
	input  logic       PSEL,
	input  logic       PENABLE,
	input  logic       PWRITE,
	input  crcu_addr_t PADDR,
	input  crcu_word_t PWDATA,
	output logic       PREADY,
	output logic       PSLVERR,
	output crcu_word_t PRDATA,
	crcu_reg_if.ctrl   reg_bus
);

	crcu_phase_e phase; // Where the current transfer stands
	logic        strobe; // First access cycle of a live transfer

	// Access starts only after a seen setup, never while responding
	assign strobe = PSEL && PENABLE && (phase == phase_setup) && !PREADY;

	// Address and data go straight to the bank
	assign reg_bus.addr      = PADDR;
	assign reg_bus.wdata     = PWDATA;
	assign reg_bus.wr_strobe = strobe && PWRITE;
	assign reg_bus.rd_strobe = strobe && !PWRITE;

	// Phase tracking
	always_ff @(posedge PCLK) begin
		if (!PRESETN) begin
			phase <= phase_idle;
		end else begin
			case (phase)
				phase_idle: begin
					if (PSEL && !PENABLE) begin // Setup cycle
						phase <= phase_setup;
					end
				end
				phase_setup: begin
					if (!PSEL) begin // Master gave up, no strobe
						phase <= phase_idle;
					end else if (PENABLE) begin // Strobe fires now
						phase <= phase_access;
					end
				end
				phase_access: begin
					// Transfer completes on this edge
					phase <= phase_idle;
				end
				default: begin
					phase <= phase_idle;
				end
			endcase
		end
	end

	// Response registers, valid for the single PREADY cycle
	always_ff @(posedge PCLK) begin
		if (!PRESETN) begin
			PREADY  <= 1'b0;
			PSLVERR <= 1'b0;
			PRDATA  <= '0;
		end else begin
			PREADY  <= strobe; // One cycle after PENABLE
			PSLVERR <= strobe && reg_bus.err;
			if (reg_bus.rd_strobe && !reg_bus.err) begin
				PRDATA <= reg_bus.rdata; // Good read only
			end else begin
				PRDATA <= '0; // Writes, errors, idle
			end
		end
	end

endmodule

// File: verilog/crcu_defs.svh
/*
  Shared constants for the clock and reset control unit register block.
  Include this file wherever the data width, bank size or register map
  offsets are needed. The register types built on these constants are
  in the package.
*/
`ifndef CRCU_DEFS_SVH
`define CRCU_DEFS_SVH

// APB bus widths
`define CRCU_DATA_W 32 // Data and register width
`define CRCU_ADDR_W 32 // APB address width

// Words held in each control bank
`define CRCU_BANK_WORDS 8

// Region base offsets within the slave
`define CRCU_CLK_CTL_BASE 32'h0000_0000 // Clock control, R/W
`define CRCU_CLK_STS_BASE 32'h0000_0020 // Clock status, RO mirror
`define CRCU_RST_CTL_BASE 32'h0000_0040 // Reset control, R/W
`define CRCU_RST_STS_BASE 32'h0000_0060 // Reset status, RO mirror

// Last word offset that decodes to a register
`define CRCU_MAP_TOP 32'h0000_007C

// Word index bits inside one 0x20 region
`define CRCU_IDX_MASK 32'h0000_001C

// Value of every control word after reset
`define CRCU_CTL_RESET 32'h0000_0000

`endif

// File: verilog/crcu_pkg.sv
/*
  Types shared by the register block and its testbench.
  Import with a wildcard in the module header; the widths come from
  the defines header, which this package pulls in.
*/
`include "crcu_defs.svh"

package crcu_pkg;

	// One register word as seen on the APB data bus
	typedef logic [`CRCU_DATA_W-1:0] crcu_word_t;

	// One full bank of control words, word 0 at the region base
	typedef crcu_word_t [`CRCU_BANK_WORDS-1:0] crcu_bank_t;

	// APB byte address
	typedef logic [`CRCU_ADDR_W-1:0] crcu_addr_t;

	// Word index inside a bank
	typedef logic [$clog2(`CRCU_BANK_WORDS)-1:0] crcu_idx_t;

	// Region an address falls into
	typedef enum logic [2:0] {
		region_clk_ctl, // 0x00-0x1C
		region_clk_sts, // 0x20-0x3C
		region_rst_ctl, // 0x40-0x5C
		region_rst_sts, // 0x60-0x7C
		region_unmapped // Misaligned or beyond the map
	} crcu_region_e;

	// Slave side view of the APB transfer
	typedef enum logic [1:0] {
		phase_idle,   // No transfer seen
		phase_setup,  // Setup cycle seen, next is first access cycle
		phase_access  // Response cycle, PREADY high
	} crcu_phase_e;

endpackage

// File: verilog/crcu_reg_bank.sv
/*
  Register storage and decode for the clock and reset control unit.
  Holds the clock and reset control banks, mirrors them into the status
  regions, and answers each strobe from the controller with read data and
  an error flag in the same cycle. Written words drive the output buses.
*/
`timescale 1ns/1ps

`include "crcu_defs.svh"

module crcu_reg_bank
	import crcu_pkg::*;
(
	input  logic       PCLK,
	input  logic       PRESETN, // Synchronous, active low
	crcu_reg_if.bank   reg_bus,
	output crcu_bank_t clk_ctl,  // Clock control words
	output crcu_bank_t rst_ctl   // Reset control words
);

	crcu_bank_t   clk_bank;    // Clock control storage
	crcu_bank_t   rst_bank;    // Reset control storage
	crcu_region_e region;      // Decoded region
	crcu_addr_t   region_base; // Address with word bits cleared
	crcu_idx_t    idx;         // Word within region
	logic         is_ctl;      // Region accepts writes
	logic         aligned;     // Word aligned and inside the map
	crcu_word_t   rd_word;     // Selected word before gating

	// Address split
	assign region_base = reg_bus.addr & ~`CRCU_IDX_MASK;
	assign idx         = crcu_idx_t'((reg_bus.addr & `CRCU_IDX_MASK) >> 2);
	assign aligned     = (reg_bus.addr[1:0] == 2'b00) && (reg_bus.addr <= `CRCU_MAP_TOP);

	// Region decode
	always_comb begin
		region = region_unmapped;
		if (aligned) begin
			case (region_base)
				`CRCU_CLK_CTL_BASE: region = region_clk_ctl;
				`CRCU_CLK_STS_BASE: region = region_clk_sts;
				`CRCU_RST_CTL_BASE: region = region_rst_ctl;
				`CRCU_RST_STS_BASE: region = region_rst_sts;
				default:            region = region_unmapped;
			endcase
		end
	end

	assign is_ctl = (region == region_clk_ctl) || (region == region_rst_ctl);

	// Status writes and unmapped reads are both errors
	assign reg_bus.err = (reg_bus.wr_strobe && !is_ctl) ||
		(reg_bus.rd_strobe && (region == region_unmapped));

	// Read mux, status regions mirror their control bank
	always_comb begin
		case (region)
			region_clk_ctl,
			region_clk_sts: begin
				rd_word = clk_bank[idx];
			end
			region_rst_ctl,
			region_rst_sts: begin
				rd_word = rst_bank[idx];
			end
			default: begin
				rd_word = '0; // Unmapped reads as zero
			end
		endcase
	end

	assign reg_bus.rdata = reg_bus.rd_strobe ? rd_word : '0;

	// Control storage, updated on the edge ending the strobe cycle
	always_ff @(posedge PCLK) begin
		if (!PRESETN) begin
			clk_bank <= {`CRCU_BANK_WORDS{crcu_word_t'(`CRCU_CTL_RESET)}};
			rst_bank <= {`CRCU_BANK_WORDS{crcu_word_t'(`CRCU_CTL_RESET)}};
		end else if (reg_bus.wr_strobe && !reg_bus.err) begin
			case (region)
				region_clk_ctl: begin
					clk_bank[idx] <= reg_bus.wdata;
				end
				region_rst_ctl: begin
					rst_bank[idx] <= reg_bus.wdata;
				end
				default: begin
					// Error path, nothing stored
				end
			endcase
		end
	end

	// Outputs follow storage, new value visible with PREADY
	assign clk_ctl = clk_bank;
	assign rst_ctl = rst_bank;

endmodule

// File: verilog/crcu_reg_if.sv
/*
  Internal link between the APB protocol controller and the register bank.
  The controller pulses one strobe per transfer and the bank answers with
  read data and an error flag in the same cycle.
*/
`timescale 1ns/1ps

interface crcu_reg_if
	import crcu_pkg::*;
();

	crcu_addr_t addr;      // Transfer address
	crcu_word_t wdata;     // Write data
	logic       wr_strobe; // Single cycle write request
	logic       rd_strobe; // Single cycle read request
	crcu_word_t rdata;     // Read data, combinational
	logic       err;       // Access error, combinational

	modport ctrl (
		output addr,
		output wdata,
		output wr_strobe,
		output rd_strobe,
		input  rdata,
		input  err
	);

	modport bank (
		input  addr,
		input  wdata,
		input  wr_strobe,
		input  rd_strobe,
		output rdata,
		output err
	);

endinterface

// File: verilog/crcu_regs.sv
/*
  Top level of the clock and reset control unit register block.
  An APB slave with eight clock control and eight reset control words,
  plus read-only status words that mirror them. Control words leave the
  block on the clk_ctl and rst_ctl buses. Every transfer takes one wait
  state; unmapped reads and writes to anything but control answer PSLVERR.
*/
`timescale 1ns/1ps

module crcu_regs
	import crcu_pkg::*;
(
	// APB slave port
	input  logic       PCLK,
	input  logic       PRESETN, // Synchronous, active low
	input  logic       PSEL,
	input  logic       PENABLE,
	input  logic       PWRITE,
	input  crcu_addr_t PADDR,
	input  crcu_word_t PWDATA,
	output logic       PREADY,  // High for one cycle per transfer
	output logic       PSLVERR, // Qualified by PREADY
	output crcu_word_t PRDATA,  // Zero outside a read response

	// Control outputs
	output crcu_bank_t clk_ctl, // Words from offsets 0x00-0x1C
	output crcu_bank_t rst_ctl  // Words from offsets 0x40-0x5C
);

	// Strobe link between protocol engine and storage
	crcu_reg_if reg_if ();

	// APB phase handling and response registers
	apb_access_ctrl ctrl_i (
		.PCLK    (PCLK),
		.PRESETN (PRESETN),
		.PSEL    (PSEL),
		.PENABLE (PENABLE),
		.PWRITE  (PWRITE),
		.PADDR   (PADDR),
		.PWDATA  (PWDATA),
		.PREADY  (PREADY),
		.PSLVERR (PSLVERR),
		.PRDATA  (PRDATA),
		.reg_bus (reg_if.ctrl)
	);

	// Decode, storage and status mirror
	crcu_reg_bank bank_i (
		.PCLK    (PCLK),
		.PRESETN (PRESETN),
		.reg_bus (reg_if.bank),
		.clk_ctl (clk_ctl),
		.rst_ctl (rst_ctl)
	);

endmodule
